//--- logic/pc_config_pkg.sv
// shared widths, counts and encodings for the host config path
package pc_config_pkg;

  ////////////////////////////////////////////////////////////
  // widths and counts

  // host word as delivered by the PC link
  localparam int PC_W = 32;
  // config data carried by a register or channel word
  localparam int CONF_W = 16;
  // programmable register array
  localparam int NREG = 64;
  // configuration channels, one deserializer each
  localparam int NCHAN = 2;
  localparam int REG_ID_W = 6;
  localparam int CHAN_ID_W = 1;

  // BD passthrough fields
  localparam int LEAF_W = 6;
  localparam int BD_PAYLOAD_W = 20;

  // two 16-bit beats make one channel word
  localparam int DESER_BEATS = 2;
  localparam int CHAN_WORD_W = 32;
  localparam int BEAT_CNT_W = $clog2(DESER_BEATS);

  ////////////////////////////////////////////////////////////
  // word layout

  // bit 31 splits BD from FPGA words, bit 30 splits reg from chan
  localparam int KIND_FPGA_BIT = 31;
  localparam int KIND_CHAN_BIT = 30;
  // leaf code, reg id and chan id all start here
  localparam int FIELD_ID_LSB = 24;

  // every register comes out of reset with this value
  localparam logic [CONF_W-1:0] REG_RESET_VAL = '0;

  ////////////////////////////////////////////////////////////
  // enums

  typedef enum logic [1:0] {
    WORD_BD,
    WORD_REG,
    WORD_CHAN
  } word_kind_e;

  typedef enum logic {
    DESER_COLLECT,
    DESER_FULL
  } deser_state_e;

endpackage

//--- logic/pc_word_parser.sv
`timescale 1ns/1ps

// first stage of host config parsing
//
// word layout, MSB first
//   BD   : [ 0 | x | leaf_code(6) | x(4) | payload(20) ]
//   reg  : [ 1 | 0 | reg_id(6)    | x(8) | data(16)    ]
//   chan : [ 1 | 1 | chan_id(6)   | x(8) | data(16)    ]
module pc_word_parser (
  input  logic clk,
  input  logic reset,

  // host side, throttled by stall
  input  logic stall,
  input  logic pc_valid,
  input  logic [pc_config_pkg::PC_W-1:0] pc_word,
  output logic pc_ack,

  // BD-bound passthrough
  output logic bd_valid,
  output logic [pc_config_pkg::LEAF_W-1:0] bd_leaf_code,
  output logic [pc_config_pkg::BD_PAYLOAD_W-1:0] bd_payload,
  input  logic bd_ack,

  // beats to the per-channel deserializers
  output logic [pc_config_pkg::NCHAN-1:0] beat_valid,
  output logic [pc_config_pkg::CONF_W-1:0] beat_data,
  input  logic [pc_config_pkg::NCHAN-1:0] beat_ack,

  // register array
  output logic [pc_config_pkg::NREG-1:0][pc_config_pkg::CONF_W-1:0] conf_reg
);

  ////////////////////////////////////////////////////////////
  // stall gating and field split

  // the word is only offered downstream while not stalled
  logic in_valid;
  assign in_valid = pc_valid && !stall;

  pc_config_pkg::word_kind_e kind;
  logic [pc_config_pkg::REG_ID_W-1:0] reg_id;
  logic [pc_config_pkg::CHAN_ID_W-1:0] chan_sel;
  logic [pc_config_pkg::CONF_W-1:0] conf_data;

  // reg and chan words share the same id/data positions
  assign reg_id = pc_word[pc_config_pkg::FIELD_ID_LSB +: pc_config_pkg::REG_ID_W];
  // only the low bits of the chan id pick a channel
  assign chan_sel = pc_word[pc_config_pkg::FIELD_ID_LSB +: pc_config_pkg::CHAN_ID_W];
  assign conf_data = pc_word[pc_config_pkg::CONF_W-1:0];

  // classify on the top two code bits
  always_comb begin
    if (!pc_word[pc_config_pkg::KIND_FPGA_BIT]) begin
      kind = pc_config_pkg::WORD_BD;
    end else if (!pc_word[pc_config_pkg::KIND_CHAN_BIT]) begin
      kind = pc_config_pkg::WORD_REG;
    end else begin
      kind = pc_config_pkg::WORD_CHAN;
    end
  end

  ////////////////////////////////////////////////////////////
  // register array

  // reg words never wait, so valid alone is the write strobe
  logic reg_we;
  assign reg_we = in_valid && (kind == pc_config_pkg::WORD_REG);

  // new value lands on the accepting edge
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < pc_config_pkg::NREG; i++) begin
        conf_reg[i] <= pc_config_pkg::REG_RESET_VAL;
      end
    end else if (reg_we) begin
      conf_reg[reg_id] <= conf_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // channel beats

  logic chan_word_in;
  assign chan_word_in = in_valid && (kind == pc_config_pkg::WORD_CHAN);

  // one-hot: exactly the addressed deserializer sees valid
  always_comb begin
    for (int i = 0; i < pc_config_pkg::NCHAN; i++) begin
      beat_valid[i] = chan_word_in && (chan_sel == pc_config_pkg::CHAN_ID_W'(i));
    end
  end

  // data is shared, valid does the steering
  assign beat_data = conf_data;

  ////////////////////////////////////////////////////////////
  // BD passthrough

  // zero cycles, straight from the gated input
  assign bd_valid = in_valid && (kind == pc_config_pkg::WORD_BD);
  assign bd_leaf_code = pc_word[pc_config_pkg::FIELD_ID_LSB +: pc_config_pkg::LEAF_W];
  assign bd_payload = pc_word[pc_config_pkg::BD_PAYLOAD_W-1:0];

  ////////////////////////////////////////////////////////////
  // host ack

  // no slack here, ack comes straight from the chosen sink
  always_comb begin
    pc_ack = 1'b0;
    if (in_valid) begin
      case (kind)
        pc_config_pkg::WORD_BD: pc_ack = bd_ack;
        pc_config_pkg::WORD_REG: pc_ack = 1'b1;
        pc_config_pkg::WORD_CHAN: pc_ack = beat_ack[chan_sel];
        default: pc_ack = 1'b0;
      endcase
    end
  end

endmodule

//--- logic/conf_chan_deserializer.sv
`timescale 1ns/1ps

// packs DESER_BEATS config beats into one channel word
// first beat ends up in the low half
module conf_chan_deserializer (
  input  logic clk,
  input  logic reset,

  // beats from the parser
  input  logic beat_valid,
  input  logic [pc_config_pkg::CONF_W-1:0] beat_data,
  output logic beat_ack,

  // full word to the collector
  output logic full_valid,
  output logic [pc_config_pkg::CHAN_WORD_W-1:0] full_data,
  input  logic full_ack
);

  pc_config_pkg::deser_state_e state;
  logic [pc_config_pkg::BEAT_CNT_W-1:0] beat_cnt;
  logic [pc_config_pkg::CHAN_WORD_W-1:0] shift_q;

  logic beat_xfer;
  logic full_xfer;
  logic last_beat;

  ////////////////////////////////////////////////////////////
  // handshakes

  // refuse beats while a word waits to be drained
  assign beat_ack = (state == pc_config_pkg::DESER_COLLECT);
  assign full_valid = (state == pc_config_pkg::DESER_FULL);

  assign beat_xfer = beat_valid && beat_ack;
  assign full_xfer = full_valid && full_ack;
  assign last_beat = (beat_cnt == pc_config_pkg::BEAT_CNT_W'(pc_config_pkg::DESER_BEATS - 1));

  ////////////////////////////////////////////////////////////
  // state and beat count

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= pc_config_pkg::DESER_COLLECT;
      beat_cnt <= '0;
    end else begin
      case (state)
        pc_config_pkg::DESER_COLLECT: begin
          if (beat_xfer) begin
            if (last_beat) begin
              // word complete, hold it for the collector
              state <= pc_config_pkg::DESER_FULL;
              beat_cnt <= '0;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        pc_config_pkg::DESER_FULL: begin
          if (full_xfer) begin
            state <= pc_config_pkg::DESER_COLLECT;
          end
        end
        default: state <= pc_config_pkg::DESER_COLLECT;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // shift register

  // new beats enter at the top and move down,
  // so the oldest beat sits in the low half
  always_ff @(posedge clk) begin
    if (beat_xfer) begin
      shift_q <= {beat_data, shift_q[pc_config_pkg::CHAN_WORD_W-1:pc_config_pkg::CONF_W]};
    end
  end

  assign full_data = shift_q;

endmodule

//--- logic/conf_chan_collector.sv
`timescale 1ns/1ps

// round-robin drain of the channel deserializers onto one tagged output
module conf_chan_collector (
  input  logic clk,
  input  logic reset,

  // from the deserializers
  input  logic [pc_config_pkg::NCHAN-1:0] full_valid,
  input  logic [pc_config_pkg::NCHAN-1:0][pc_config_pkg::CHAN_WORD_W-1:0] full_data,
  output logic [pc_config_pkg::NCHAN-1:0] full_ack,

  // merged output
  output logic out_valid,
  output logic [pc_config_pkg::CHAN_ID_W-1:0] out_chan_id,
  output logic [pc_config_pkg::CHAN_WORD_W-1:0] out_data,
  input  logic out_ack
);

  // next channel to look at first
  logic [pc_config_pkg::CHAN_ID_W-1:0] rr_ptr;
  // set while an offered word is waiting on out_ack
  logic locked;
  logic [pc_config_pkg::CHAN_ID_W-1:0] locked_id;

  logic [pc_config_pkg::CHAN_ID_W-1:0] search_id;
  logic [pc_config_pkg::CHAN_ID_W-1:0] grant_id;
  logic out_xfer;

  ////////////////////////////////////////////////////////////
  // arbitration

  // scan from the pointer, first valid channel wins
  // falls back to the pointer itself when nothing is valid
  always_comb begin
    int idx;
    logic found;
    search_id = rr_ptr;
    found = 1'b0;
    for (int off = 0; off < pc_config_pkg::NCHAN; off++) begin
      idx = (int'(rr_ptr) + off) % pc_config_pkg::NCHAN;
      if (!found && full_valid[idx]) begin
        found = 1'b1;
        search_id = pc_config_pkg::CHAN_ID_W'(idx);
      end
    end
  end

  // a word already on offer keeps the grant until taken
  assign grant_id = locked ? locked_id : search_id;

  ////////////////////////////////////////////////////////////
  // output mux, zero cycles from full_valid

  assign out_valid = full_valid[grant_id];
  assign out_chan_id = grant_id;
  assign out_data = full_data[grant_id];
  assign out_xfer = out_valid && out_ack;

  // ack only the granted deserializer
  always_comb begin
    for (int i = 0; i < pc_config_pkg::NCHAN; i++) begin
      full_ack[i] = out_ack && out_valid && (grant_id == pc_config_pkg::CHAN_ID_W'(i));
    end
  end

  ////////////////////////////////////////////////////////////
  // pointer and grant lock

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      rr_ptr <= '0;
      locked <= 1'b0;
      locked_id <= '0;
    end else if (out_xfer) begin
      // move past the channel just served
      if (grant_id == pc_config_pkg::CHAN_ID_W'(pc_config_pkg::NCHAN - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_id + 1'b1;
      end
      locked <= 1'b0;
    end else if (out_valid) begin
      locked <= 1'b1;
      locked_id <= grant_id;
    end
  end

endmodule

//--- logic/pc_config_top.sv
`timescale 1ns/1ps

// host config path, first stage
// parser -> per-channel deserializers -> round-robin collector
module pc_config_top (
  input  logic clk,
  input  logic reset,

  // host input
  input  logic stall,
  input  logic pc_valid,
  input  logic [pc_config_pkg::PC_W-1:0] pc_word,
  output logic pc_ack,

  // BD-bound passthrough
  output logic bd_valid,
  output logic [pc_config_pkg::LEAF_W-1:0] bd_leaf_code,
  output logic [pc_config_pkg::BD_PAYLOAD_W-1:0] bd_payload,
  input  logic bd_ack,

  // register array
  output logic [pc_config_pkg::NREG-1:0][pc_config_pkg::CONF_W-1:0] conf_reg,

  // merged channel words
  output logic out_valid,
  output logic [pc_config_pkg::CHAN_ID_W-1:0] out_chan_id,
  output logic [pc_config_pkg::CHAN_WORD_W-1:0] out_data,
  input  logic out_ack
);

  // parser to deserializers
  logic [pc_config_pkg::NCHAN-1:0] beat_valid;
  logic [pc_config_pkg::NCHAN-1:0] beat_ack;
  logic [pc_config_pkg::CONF_W-1:0] beat_data;

  // deserializers to collector
  logic [pc_config_pkg::NCHAN-1:0] full_valid;
  logic [pc_config_pkg::NCHAN-1:0] full_ack;
  logic [pc_config_pkg::NCHAN-1:0][pc_config_pkg::CHAN_WORD_W-1:0] full_data;

  pc_word_parser u_parser (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .pc_valid     (pc_valid),
    .pc_word      (pc_word),
    .pc_ack       (pc_ack),
    .bd_valid     (bd_valid),
    .bd_leaf_code (bd_leaf_code),
    .bd_payload   (bd_payload),
    .bd_ack       (bd_ack),
    .beat_valid   (beat_valid),
    .beat_data    (beat_data),
    .beat_ack     (beat_ack),
    .conf_reg     (conf_reg)
  );

  ////////////////////////////////////////////////////////////
  // one deserializer per channel

  for (genvar g = 0; g < pc_config_pkg::NCHAN; g++) begin : g_deser
    conf_chan_deserializer u_deser (
      .clk        (clk),
      .reset      (reset),
      .beat_valid (beat_valid[g]),
      .beat_data  (beat_data),
      .beat_ack   (beat_ack[g]),
      .full_valid (full_valid[g]),
      .full_data  (full_data[g]),
      .full_ack   (full_ack[g])
    );
  end

  conf_chan_collector u_collector (
    .clk         (clk),
    .reset       (reset),
    .full_valid  (full_valid),
    .full_data   (full_data),
    .full_ack    (full_ack),
    .out_valid   (out_valid),
    .out_chan_id (out_chan_id),
    .out_data    (out_data),
    .out_ack     (out_ack)
  );

endmodule

//--- tb/pc_config_asserts.sv
`timescale 1ns/1ps

// protocol checks on the host config path, bound into pc_config_top
module pc_config_asserts (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic pc_ack,
  input logic bd_valid,
  input logic [pc_config_pkg::NCHAN-1:0] beat_valid,
  input logic [pc_config_pkg::NCHAN-1:0] full_valid,
  // one flag per channel, set while that deserializer is in DESER_FULL
  input logic [pc_config_pkg::NCHAN-1:0] deser_full,
  input logic out_valid,
  input logic [pc_config_pkg::CHAN_ID_W-1:0] out_chan_id,
  input logic [pc_config_pkg::CHAN_WORD_W-1:0] out_data,
  input logic out_ack
);

  ////////////////////////////////////////////////////////////
  // host side

  // stall blocks every acceptance
  a_stall_blocks_ack: assert property (@(posedge clk) disable iff (reset)
    stall |-> !pc_ack)
    else $error("pc_ack was high while stall was high");

  ////////////////////////////////////////////////////////////
  // deserializers and output

  a_full_matches_state: assert property (@(posedge clk) disable iff (reset)
    full_valid == deser_full)
    else $error("full_valid disagrees with the deserializer state");

  // offered word holds until taken
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ack) |=> (out_valid && $stable(out_data) && $stable(out_chan_id)))
    else $error("output word changed before out_ack");

  // first reset edge may still see power-up values
  a_quiet_in_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |->
      (!pc_ack && !bd_valid && !out_valid && beat_valid == '0 && full_valid == '0))
    else $error("a valid output was high during reset");

endmodule

//--- tb/pc_config_tb.sv
`timescale 1ns/1ps

module pc_config_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  // watchdog budget per stimulus record
  localparam int CYCLES_PER_LINE = 50;
  // time for the outputs to empty after the last send
  localparam int DRAIN_CYCLES = 200;
  localparam string STIM_FILE = "tb/pc_config_stimulus.txt";

  // DUT inputs, all start at a known value
  logic clk = 1'b0;
  logic reset = 1'b1;
  logic stall = 1'b0;
  logic pc_valid = 1'b0;
  logic [pc_config_pkg::PC_W-1:0] pc_word = '0;
  logic bd_ack = 1'b0;
  logic out_ack = 1'b0;

  // DUT outputs
  logic pc_ack;
  logic bd_valid;
  logic [pc_config_pkg::LEAF_W-1:0] bd_leaf_code;
  logic [pc_config_pkg::BD_PAYLOAD_W-1:0] bd_payload;
  logic [pc_config_pkg::NREG-1:0][pc_config_pkg::CONF_W-1:0] conf_reg;
  logic out_valid;
  logic [pc_config_pkg::CHAN_ID_W-1:0] out_chan_id;
  logic [pc_config_pkg::CHAN_WORD_W-1:0] out_data;

  integer seed = 32'h40ce_c816;

  // stimulus and expected results, one queue per stream
  logic [pc_config_pkg::PC_W-1:0] send_q[$];
  logic [pc_config_pkg::LEAF_W-1:0] bd_leaf_q[$];
  logic [pc_config_pkg::BD_PAYLOAD_W-1:0] bd_payload_q[$];
  logic [pc_config_pkg::CHAN_WORD_W-1:0] chan_q[pc_config_pkg::NCHAN][$];
  logic [pc_config_pkg::REG_ID_W-1:0] reg_id_q[$];
  logic [pc_config_pkg::CONF_W-1:0] reg_val_q[$];
  int n_records = 0;
  logic stim_loaded = 1'b0;

  pc_config_top u_pc_config_top (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .pc_valid     (pc_valid),
    .pc_word      (pc_word),
    .pc_ack       (pc_ack),
    .bd_valid     (bd_valid),
    .bd_leaf_code (bd_leaf_code),
    .bd_payload   (bd_payload),
    .bd_ack       (bd_ack),
    .conf_reg     (conf_reg),
    .out_valid    (out_valid),
    .out_chan_id  (out_chan_id),
    .out_data     (out_data),
    .out_ack      (out_ack)
  );

  // NCHAN is 2, one state compare per deserializer
  bind pc_config_top pc_config_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .pc_ack      (pc_ack),
    .bd_valid    (bd_valid),
    .beat_valid  (beat_valid),
    .full_valid  (full_valid),
    .deser_full  ({g_deser[1].u_deser.state == pc_config_pkg::DESER_FULL,
                   g_deser[0].u_deser.state == pc_config_pkg::DESER_FULL}),
    .out_valid   (out_valid),
    .out_chan_id (out_chan_id),
    .out_data    (out_data),
    .out_ack     (out_ack)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reporting and compare tasks

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bd(input string name,
                          input logic [pc_config_pkg::LEAF_W-1:0] exp_leaf,
                          input logic [pc_config_pkg::BD_PAYLOAD_W-1:0] exp_payload,
                          input logic [pc_config_pkg::LEAF_W-1:0] act_leaf,
                          input logic [pc_config_pkg::BD_PAYLOAD_W-1:0] act_payload);
    if (act_leaf !== exp_leaf || act_payload !== exp_payload) begin
      abort_run($sformatf("ERROR %s: expected leaf %h payload %h, actual leaf %h payload %h",
                          name, exp_leaf, exp_payload, act_leaf, act_payload));
    end
  endtask

  task automatic check_chan(input string name,
                            input logic [pc_config_pkg::CHAN_ID_W-1:0] exp_id,
                            input logic [pc_config_pkg::CHAN_WORD_W-1:0] exp_word,
                            input logic [pc_config_pkg::CHAN_ID_W-1:0] act_id,
                            input logic [pc_config_pkg::CHAN_WORD_W-1:0] act_word);
    if (act_id !== exp_id || act_word !== exp_word) begin
      abort_run($sformatf("ERROR %s: expected chan %0d word %h, actual chan %0d word %h",
                          name, exp_id, exp_word, act_id, act_word));
    end
  endtask

  task automatic check_reg(input string name,
                           input logic [pc_config_pkg::CONF_W-1:0] exp_val,
                           input logic [pc_config_pkg::CONF_W-1:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp_val, act_val));
    end
  endtask

  // expected results not yet seen at the outputs
  function automatic int pending_count();
    int total;
    total = bd_leaf_q.size();
    for (int i = 0; i < pc_config_pkg::NCHAN; i++) begin
      total += chan_q[i].size();
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus file, one opcode letter and two hex fields per record

  task automatic load_stimulus();
    int fd;
    int c;
    int n;
    logic [7:0] op;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run({"could not open the stimulus file ", STIM_FILE});
    end
    c = $fgetc(fd);
    while (c != -1) begin
      op = c[7:0];
      if (op == "#") begin
        // comment runs to end of line
        while (c != -1 && c[7:0] != "\n") begin
          c = $fgetc(fd);
        end
      end else if (op == "S" || op == "B" || op == "C" || op == "R") begin
        n = $fscanf(fd, "%h %h", a, b);
        if (n != 2) begin
          abort_run("a stimulus record is missing one of its hex fields");
        end
        n_records++;
        case (op)
          "S": send_q.push_back(a);
          "B": begin
            bd_leaf_q.push_back(a[pc_config_pkg::LEAF_W-1:0]);
            bd_payload_q.push_back(b[pc_config_pkg::BD_PAYLOAD_W-1:0]);
          end
          "C": chan_q[a[pc_config_pkg::CHAN_ID_W-1:0]].push_back(b);
          default: begin
            reg_id_q.push_back(a[pc_config_pkg::REG_ID_W-1:0]);
            reg_val_q.push_back(b[pc_config_pkg::CONF_W-1:0]);
          end
        endcase
      end else if (op != " " && op != "\n" && op != "\r" && op != "\t") begin
        abort_run($sformatf("the stimulus file has an unknown opcode %c", op));
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // caller sits on a rising edge, returns on the accepting edge
  task automatic send_word(input logic [pc_config_pkg::PC_W-1:0] word);
    pc_valid <= 1'b1;
    pc_word <= word;
    do begin
      @(negedge clk);
    end while (!(pc_valid && pc_ack));
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // random back-pressure and stall

  always @(posedge clk) begin
    stall <= ($random(seed) & 3) == 0;
    bd_ack <= ($random(seed) & 3) != 0;
    // out_ack low half the time so deserializers fill up
    out_ack <= ($random(seed) & 1) == 1;
  end

  ////////////////////////////////////////////////////////////
  // monitors, sampled mid-cycle where the handshake is settled

  always @(negedge clk) begin
    if (!reset && bd_valid && bd_ack) begin
      if (bd_leaf_q.size() == 0) begin
        abort_run($sformatf("a BD word with payload %h came out with none expected", bd_payload));
      end else begin
        check_bd("bd passthrough", bd_leaf_q.pop_front(), bd_payload_q.pop_front(),
                 bd_leaf_code, bd_payload);
      end
    end
  end

  // expected channel is the queue whose head holds this word
  always @(negedge clk) begin
    int exp_id;
    if (!reset && out_valid && out_ack) begin
      exp_id = -1;
      for (int i = 0; i < pc_config_pkg::NCHAN; i++) begin
        if (exp_id < 0 && chan_q[i].size() != 0 && chan_q[i][0] === out_data) begin
          exp_id = i;
        end
      end
      // no head matches, compare against the first channel still waiting
      for (int i = 0; i < pc_config_pkg::NCHAN; i++) begin
        if (exp_id < 0 && chan_q[i].size() != 0) begin
          exp_id = i;
        end
      end
      if (exp_id < 0) begin
        abort_run($sformatf("channel %0d delivered word %h with none expected",
                            out_chan_id, out_data));
      end else begin
        check_chan($sformatf("chan %0d word", exp_id), pc_config_pkg::CHAN_ID_W'(exp_id),
                   chan_q[exp_id].pop_front(), out_chan_id, out_data);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin : main_seq
    int wait_cnt;
    load_stimulus();
    stim_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    foreach (send_q[i]) begin
      send_word(send_q[i]);
    end
    pc_valid <= 1'b0;
    wait_cnt = 0;
    while (pending_count() != 0 && wait_cnt < DRAIN_CYCLES) begin
      @(posedge clk);
      wait_cnt++;
    end
    // last register write has landed by now
    @(negedge clk);
    foreach (reg_id_q[i]) begin
      check_reg($sformatf("reg %0d", reg_id_q[i]), reg_val_q[i], conf_reg[reg_id_q[i]]);
    end
    if (pending_count() != 0) begin
      abort_run($sformatf("%0d expected output words never arrived", pending_count()));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  initial begin : watchdog
    wait (stim_loaded);
    repeat (RESET_CYCLES + n_records * CYCLES_PER_LINE) @(posedge clk);
    abort_run("timeout, the test did not finish in its cycle budget");
  end

endmodule

//--- verilog.f
logic/pc_config_pkg.sv
logic/pc_word_parser.sv
logic/conf_chan_deserializer.sv
logic/conf_chan_collector.sv
logic/pc_config_top.sv
tb/pc_config_asserts.sv
tb/pc_config_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pc_config testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module pc_config_tb -f verilog.f -o pc_config_sim

# a failing run exits nonzero, the log is searched below
./obj_dir/pc_config_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi

//--- tb/pc_config_stimulus.txt
# op field_a field_b : S word 0 | B leaf payload | C chan_id chan_word | R reg_id value
# S sends a host word, B/C are expected outputs, R is checked after the sends
S 15FABCDE 0
B 15 ABCDE
S 7A312345 0
B 3A 12345
S 85FF1234 0
S BF00BEEF 0
S 80000001 0
S 80000002 0
S C0001111 0
S C0002222 0
C 0 22221111
S C100AAAA 0
S C0003333 0
S C100BBBB 0
S C0004444 0
C 1 BBBBAAAA
C 0 44443333
S FF000001 0
S C1000002 0
S C1000003 0
S C1000004 0
S C1000005 0
S C1000006 0
C 1 00020001
C 1 00040003
C 1 00060005
S C2005555 0
S 0100000F 0
B 01 0000F
S C0006666 0
C 0 66665555
S 3F0FFFFF 0
B 3F FFFFF
R 00 0002
R 05 1234
R 3F BEEF
R 01 0000
R 04 0000
R 06 0000
R 3E 0000
